// ==== vlog.f ====
+incdir+design
design/isaPkg.sv
design/ctrlPkg.sv
design/registerFile.sv
design/aluUnit.sv
design/operandPath.sv
design/resultPath.sv
design/controlUnit.sv
design/armCore.sv
tb/storeChecker.sv
tb/armCoreTb.sv

// ==== tb/armCoreTb.sv ====
// Testbench top: clock, reset, memory model with program image, run limit and final report
`default_nettype none
`include "armCore_cfg.svh"

module armCoreTb;
	localparam int MemWords  = 64;
	localparam int DpCycles  = 4;
	localparam int StrCycles = 4;
	localparam int LdrCycles = 5;
	localparam int BCycles   = 3;
	// 18 data-processing incl. MUL, 26 STR, 3 LDR and 2 branches run before the final loop
	localparam int ProgramCycles = 18 * DpCycles + 26 * StrCycles + 3 * LdrCycles + 2 * BCycles;
	localparam int CycleLimit    = 2 * ProgramCycles;
	// Time spent in the closing self-branch, any store there is a stray one
	localparam int TailCycles    = 16;

	logic                 clk;
	logic                 reset;
	logic [`ARM_XLEN-1:0] readData;
	logic [`ARM_XLEN-1:0] adr;
	logic [`ARM_XLEN-1:0] writeData;
	logic                 memWrite;
	logic [`ARM_XLEN-1:0] mem [0:MemWords-1];
	int                   mismatchCount;
	int                   unexpectedCount;
	int                   missingCount;
	int                   cycles;

	// Program and data words, the rest of memory gets an address-based fill
	function automatic logic [`ARM_XLEN-1:0] imageWord(input int idx);
		case (idx)
			0:  imageWord = 32'hE200_0000;  // AND  R0, R0, #0
			1:  imageWord = 32'hE280_105C;  // ADD  R1, R0, #0x5C
			2:  imageWord = 32'hE280_2037;  // ADD  R2, R0, #0x37
			3:  imageWord = 32'hE280_80D8;  // ADD  R8, R0, #0xD8
			4:  imageWord = 32'hE081_3002;  // ADD  R3, R1, R2
			5:  imageWord = 32'hE588_3000;  // STR  R3, [R8, #0x00]
			6:  imageWord = 32'hE041_3002;  // SUB  R3, R1, R2
			7:  imageWord = 32'hE588_3004;  // STR  R3, [R8, #0x04]
			8:  imageWord = 32'hE001_3002;  // AND  R3, R1, R2
			9:  imageWord = 32'hE588_3008;  // STR  R3, [R8, #0x08]
			10: imageWord = 32'hE181_3002;  // ORR  R3, R1, R2
			11: imageWord = 32'hE588_300C;  // STR  R3, [R8, #0x0C]
			12: imageWord = 32'hE021_3002;  // EOR  R3, R1, R2
			13: imageWord = 32'hE588_3010;  // STR  R3, [R8, #0x10]
			14: imageWord = 32'hE281_30A5;  // ADD  R3, R1, #0xA5
			15: imageWord = 32'hE588_3014;  // STR  R3, [R8, #0x14]
			16: imageWord = 32'hE241_300F;  // SUB  R3, R1, #0x0F
			17: imageWord = 32'hE588_3018;  // STR  R3, [R8, #0x18]
			18: imageWord = 32'hE201_30F0;  // AND  R3, R1, #0xF0
			19: imageWord = 32'hE588_301C;  // STR  R3, [R8, #0x1C]
			20: imageWord = 32'hE381_3003;  // ORR  R3, R1, #0x03
			21: imageWord = 32'hE588_3020;  // STR  R3, [R8, #0x20]
			22: imageWord = 32'hE221_30FF;  // EOR  R3, R1, #0xFF
			23: imageWord = 32'hE588_3024;  // STR  R3, [R8, #0x24]
			24: imageWord = 32'hE588_3004;  // STR  R3, [R8, #0x04]
			25: imageWord = 32'hE598_5004;  // LDR  R5, [R8, #0x04]
			26: imageWord = 32'hE588_5008;  // STR  R5, [R8, #0x08]
			27: imageWord = 32'hE590_60D0;  // LDR  R6, [R0, #0xD0]
			28: imageWord = 32'hE590_70D4;  // LDR  R7, [R0, #0xD4]
			29: imageWord = 32'hE009_0796;  // MUL  R9, R6, R7
			30: imageWord = 32'hE588_900C;  // STR  R9, [R8, #0x0C]
			31: imageWord = 32'hE051_A001;  // SUBS R10, R1, R1
			32: imageWord = 32'h0588_A010;  // STREQ R10, [R8, #0x10]
			33: imageWord = 32'h1588_A014;  // STRNE R10, [R8, #0x14]
			34: imageWord = 32'hA588_A018;  // STRGE R10, [R8, #0x18]
			35: imageWord = 32'hB588_A01C;  // STRLT R10, [R8, #0x1C]
			36: imageWord = 32'h4588_A020;  // STRMI R10, [R8, #0x20]
			37: imageWord = 32'hE052_A001;  // SUBS R10, R2, R1
			38: imageWord = 32'h0588_A010;  // STREQ R10, [R8, #0x10]
			39: imageWord = 32'h1588_A014;  // STRNE R10, [R8, #0x14]
			40: imageWord = 32'hA588_A018;  // STRGE R10, [R8, #0x18]
			41: imageWord = 32'hB588_A01C;  // STRLT R10, [R8, #0x1C]
			42: imageWord = 32'h4588_A020;  // STRMI R10, [R8, #0x20]
			43: imageWord = 32'hEA00_0000;  // B    to 0xB4
			44: imageWord = 32'hE588_1000;  // STR  R1, [R8, #0x00], jumped over
			45: imageWord = 32'hE588_2000;  // STR  R2, [R8, #0x00]
			46: imageWord = 32'h0A00_0000;  // BEQ  to 0xC0, not taken
			47: imageWord = 32'hE588_1004;  // STR  R1, [R8, #0x04]
			48: imageWord = 32'hE28F_F000;  // ADD  R15, R15, #0
			49: imageWord = 32'hE588_1008;  // STR  R1, [R8, #0x08], jumped over
			50: imageWord = 32'hE588_2008;  // STR  R2, [R8, #0x08]
			51: imageWord = 32'hEAFF_FFFE;  // B    to itself
			52: imageWord = 32'h0001_0001;  // Multiplicand
			53: imageWord = 32'h0003_0003;  // Multiplier
			default: imageWord = 32'hF00D_0000 | (idx << 2);
		endcase
	endfunction

	armCore DUT (
		.clk       (clk),
		.reset     (reset),
		.readData  (readData),
		.memWrite  (memWrite),
		.adr       (adr),
		.writeData (writeData)
	);

	storeChecker storeCheck (
		.clk             (clk),
		.reset           (reset),
		.memWrite        (memWrite),
		.adr             (adr),
		.writeData       (writeData),
		.mismatchCount   (mismatchCount),
		.unexpectedCount (unexpectedCount),
		.missingCount    (missingCount)
	);

	// Combinational read, word index from the byte address
	assign readData = mem[adr[7:2]];

	always @(posedge clk) begin
		if (memWrite)
			mem[adr[7:2]] <= writeData;
	end

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial begin
		int i;
		reset  = 1'b1;
		cycles = 0;
		for (i = 0; i < MemWords; i++)
			mem[i] = imageWord(i);
		repeat (3) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		while (missingCount != 0 && cycles < CycleLimit) begin
			@(negedge clk);
			cycles++;
		end
		if (missingCount == 0)
			repeat (TailCycles) @(negedge clk);
		else
			$display("Timeout after %0d cycles with %0d expected stores still missing",
				cycles, missingCount);
		$display("Error counts: %0d mismatched, %0d unexpected, %0d missing stores",
			mismatchCount, unexpectedCount, missingCount);
		if (mismatchCount == 0 && unexpectedCount == 0 && missingCount == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb/storeChecker.sv ====
// Store checker: compares every memory write of the core with the expected store sequence
`default_nettype none
`include "armCore_cfg.svh"

module storeChecker (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 memWrite,
	input  logic [`ARM_XLEN-1:0] adr,
	input  logic [`ARM_XLEN-1:0] writeData,
	output int                   mismatchCount,
	output int                   unexpectedCount,
	output int                   missingCount
);
	localparam int NumStores = 21;

	int seenCount;

	// Expected stores in program order, address in the upper word and data in the lower
	function automatic logic [2*`ARM_XLEN-1:0] expectedStore(input int idx);
		case (idx)
			// R1 = 0x5C and R2 = 0x37, register operands
			0:  expectedStore = {32'h0000_00D8, 32'h0000_0093};
			1:  expectedStore = {32'h0000_00DC, 32'h0000_0025};
			2:  expectedStore = {32'h0000_00E0, 32'h0000_0014};
			3:  expectedStore = {32'h0000_00E4, 32'h0000_007F};
			4:  expectedStore = {32'h0000_00E8, 32'h0000_006B};
			// Immediate operands
			5:  expectedStore = {32'h0000_00EC, 32'h0000_0101};
			6:  expectedStore = {32'h0000_00F0, 32'h0000_004D};
			7:  expectedStore = {32'h0000_00F4, 32'h0000_0050};
			8:  expectedStore = {32'h0000_00F8, 32'h0000_005F};
			9:  expectedStore = {32'h0000_00FC, 32'h0000_00A3};
			// Store, load back, store the loaded word elsewhere
			10: expectedStore = {32'h0000_00DC, 32'h0000_00A3};
			11: expectedStore = {32'h0000_00E0, 32'h0000_00A3};
			// 0x00010001 * 0x00030003, low word
			12: expectedStore = {32'h0000_00E4, 32'h0006_0003};
			// Equal SUBS gives Z=1 C=1 N=0 V=0, so EQ and GE store
			13: expectedStore = {32'h0000_00E8, 32'h0000_0000};
			14: expectedStore = {32'h0000_00F0, 32'h0000_0000};
			// 0x37 - 0x5C gives N=1 and Z C V clear, so NE LT and MI store
			15: expectedStore = {32'h0000_00EC, 32'hFFFF_FFDB};
			16: expectedStore = {32'h0000_00F4, 32'hFFFF_FFDB};
			17: expectedStore = {32'h0000_00F8, 32'hFFFF_FFDB};
			// Branch target, BEQ fall-through, landing point of the R15 write
			18: expectedStore = {32'h0000_00D8, 32'h0000_0037};
			19: expectedStore = {32'h0000_00DC, 32'h0000_005C};
			20: expectedStore = {32'h0000_00E0, 32'h0000_0037};
			default: expectedStore = '0;
		endcase
	endfunction

	assign missingCount = NumStores - seenCount;

	initial begin
		mismatchCount   = 0;
		unexpectedCount = 0;
		seenCount       = 0;
	end

	// DUT outputs still hold the values of the cycle that ends at this edge
	always @(posedge clk) begin
		logic [2*`ARM_XLEN-1:0] expected;
		if (reset) begin
			if (memWrite !== 1'b0) begin
				$display("Store strobe at address %h was active while reset was asserted", adr);
				unexpectedCount++;
			end
		end else if (memWrite) begin
			if (seenCount >= NumStores) begin
				$display("Store to address %h with data %h came after the last expected store",
					adr, writeData);
				unexpectedCount++;
			end else begin
				expected = expectedStore(seenCount);
				if (adr !== expected[2*`ARM_XLEN-1:`ARM_XLEN] ||
					writeData !== expected[`ARM_XLEN-1:0]) begin
					$display("FAIL t=%0t store %0d: adr %h data %h, expected adr %h data %h",
						$time, seenCount, adr, writeData,
						expected[2*`ARM_XLEN-1:`ARM_XLEN], expected[`ARM_XLEN-1:0]);
					mismatchCount++;
				end
				seenCount++;
			end
		end
	end

endmodule

`default_nettype wire

// ==== design/armCore.sv ====
// Core top level joining the control unit with operand, ALU and result paths
`default_nettype none
`include "armCore_cfg.svh"

module armCore (
	input  logic                 clk,
	input  logic                 reset,
	input  logic [`ARM_XLEN-1:0] readData,
	output logic                 memWrite,
	output logic [`ARM_XLEN-1:0] adr,
	output logic [`ARM_XLEN-1:0] writeData
);
	import isaPkg::*;
	import ctrlPkg::*;

	logic [`ARM_XLEN-1:0] instr, srcA, srcB, aluResult, result, pcValue;
	aluFlags_t  aluFlags;
	aluOp_t     aluOp;
	srcBSel_t   srcBSel;
	resultSel_t resultSel;
	immSel_t    immSel;
	logic       pcWrite, regWrite, irWrite, adrSrc, srcASel;
	logic       ra1Pc, ra2Rd, mulRegs;

	// Port names match the nets above throughout
	controlUnit ctrl (.*);

	operandPath operands (.*);

	aluUnit alu (.*);

	resultPath results (.*);

endmodule

`default_nettype wire

// ==== design/controlUnit.sv ====
// Multicycle FSM, instruction decoder, flags register and condition check
`default_nettype none
`include "armCore_cfg.svh"

module controlUnit (
	input  logic                 clk,
	input  logic                 reset,
	input  logic [`ARM_XLEN-1:0] instr,
	input  isaPkg::aluFlags_t    aluFlags,
	output logic                 pcWrite,
	output logic                 memWrite,
	output logic                 regWrite,
	output logic                 irWrite,
	output logic                 adrSrc,
	output logic                 srcASel,
	output ctrlPkg::srcBSel_t    srcBSel,
	output ctrlPkg::resultSel_t  resultSel,
	output ctrlPkg::immSel_t     immSel,
	output logic                 ra1Pc,
	output logic                 ra2Rd,
	output logic                 mulRegs,
	output isaPkg::aluOp_t       aluOp
);
	import isaPkg::*;
	import ctrlPkg::*;

	cpuState_t state, nextState;
	aluFlags_t flags;
	opClass_t  opClass;
	dpFunct_t  funct;
	condCode_t cond;
	logic      isMul, isArith, immOp, isLoad, sBit;
	logic      condEx, condPass, ge;
	logic      nextPc, regW, memW, branch, aluDec;
	logic      destIsPc, pcRedirect;
	logic      flagWriteNZ, flagWriteCV;

	// Instruction fields
	assign opClass = opClass_t'(instr[27:26]);
	assign funct   = dpFunct_t'(instr[24:21]);
	assign cond    = condCode_t'(instr[31:28]);
	assign immOp   = instr[25];
	assign isLoad  = instr[20];
	assign sBit    = instr[20];
	assign isMul   = (instr[27:22] == 6'b000000) && (instr[7:4] == 4'b1001);
	assign isArith = !isMul && (funct == FN_ADD || funct == FN_SUB);

	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			state <= FETCH;
		else
			state <= nextState;
	end

	always_comb begin
		nextState = FETCH;
		case (state)
			FETCH: nextState = DECODE;
			DECODE: begin
				case (opClass)
					OP_DP:     nextState = immOp ? EXECUTEI : EXECUTER;
					OP_MEM:    nextState = MEMADR;
					OP_BRANCH: nextState = BRANCH;
					// Undefined class goes straight back
					default:   nextState = FETCH;
				endcase
			end
			MEMADR:   nextState = isLoad ? MEMRD : MEMWR;
			MEMRD:    nextState = MEMWB;
			EXECUTER: nextState = ALUWB;
			EXECUTEI: nextState = ALUWB;
			default:  nextState = FETCH;
		endcase
	end

	// Control word per state
	always_comb begin
		irWrite   = 1'b0;
		adrSrc    = 1'b0;
		srcASel   = 1'b0;
		srcBSel   = SRCB_REG;
		resultSel = RES_ALUOUT;
		nextPc    = 1'b0;
		regW      = 1'b0;
		memW      = 1'b0;
		branch    = 1'b0;
		aluDec    = 1'b0;
		case (state)
			FETCH: begin
				irWrite   = 1'b1;
				srcASel   = 1'b1;
				srcBSel   = SRCB_STEP;
				resultSel = RES_ALU;
				nextPc    = 1'b1;
			end
			DECODE: begin
				// PC+8 on the result bus, seen as the R15 read
				srcASel   = 1'b1;
				srcBSel   = SRCB_STEP;
				resultSel = RES_ALU;
			end
			MEMADR: srcBSel = SRCB_IMM;
			MEMRD:  adrSrc = 1'b1;
			MEMWB: begin
				resultSel = RES_DATA;
				regW      = 1'b1;
			end
			MEMWR: begin
				adrSrc = 1'b1;
				memW   = 1'b1;
			end
			EXECUTER: aluDec = 1'b1;
			EXECUTEI: begin
				srcBSel = SRCB_IMM;
				aluDec  = 1'b1;
			end
			ALUWB: regW = 1'b1;
			BRANCH: begin
				srcBSel   = SRCB_IMM;
				resultSel = RES_ALU;
				branch    = 1'b1;
			end
			default: ;
		endcase
	end

	// ALU decoder, address-only states always add
	always_comb begin
		aluOp = ALU_ADD;
		if (aluDec) begin
			if (isMul)
				aluOp = ALU_MUL;
			else begin
				case (funct)
					FN_SUB:  aluOp = ALU_SUB;
					FN_AND:  aluOp = ALU_AND;
					FN_ORR:  aluOp = ALU_ORR;
					FN_EOR:  aluOp = ALU_EOR;
					default: aluOp = ALU_ADD;
				endcase
			end
		end
	end

	// Instruction-class selects for the operand path
	assign ra1Pc   = (opClass == OP_BRANCH);
	assign ra2Rd   = (opClass == OP_MEM);
	assign mulRegs = isMul;
	assign immSel  = (opClass == OP_MEM) ? IMM_12 : (opClass == OP_BRANCH) ? IMM_BRANCH : IMM_8;

	assign ge = (flags.n == flags.v);
	always_comb begin
		case (cond)
			COND_EQ: condEx = flags.z;
			COND_NE: condEx = !flags.z;
			COND_CS: condEx = flags.c;
			COND_CC: condEx = !flags.c;
			COND_MI: condEx = flags.n;
			COND_PL: condEx = !flags.n;
			COND_VS: condEx = flags.v;
			COND_VC: condEx = !flags.v;
			COND_HI: condEx = flags.c && !flags.z;
			COND_LS: condEx = !(flags.c && !flags.z);
			COND_GE: condEx = ge;
			COND_LT: condEx = !ge;
			COND_GT: condEx = !flags.z && ge;
			COND_LE: condEx = !(!flags.z && ge);
			COND_AL: condEx = 1'b1;
			default: condEx = 1'b0;
		endcase
	end

	// Condition sampled once per instruction, at the end of DECODE
	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			condPass <= 1'b0;
		else if (state == DECODE)
			condPass <= condEx;
	end

	assign flagWriteNZ = aluDec && sBit && condPass;
	assign flagWriteCV = flagWriteNZ && isArith;

	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			flags <= '0;
		else begin
			if (flagWriteNZ) begin
				flags.n <= aluFlags.n;
				flags.z <= aluFlags.z;
			end
			if (flagWriteCV) begin
				flags.c <= aluFlags.c;
				flags.v <= aluFlags.v;
			end
		end
	end

	// A write to R15 goes to the PC instead of the register file
	assign destIsPc   = (isMul ? instr[19:16] : instr[15:12]) == `ARM_REG_ADDR_W'(`ARM_PC_REG);
	assign pcRedirect = (regW && destIsPc) || branch;

	assign pcWrite  = nextPc || (pcRedirect && condPass);
	assign regWrite = regW && condPass && !destIsPc;
	assign memWrite = memW && condPass;

	noMemRegOverlap: assert property (@(posedge clk) disable iff (reset)
		!(memWrite && regWrite));

	stateDefined: assert property (@(posedge clk) disable iff (reset)
		!$isunknown(state) && (state <= BRANCH));

endmodule

`default_nettype wire

// ==== design/resultPath.sv ====
// PC register, ALU-out and load-data registers, result select and memory address select
`default_nettype none
`include "armCore_cfg.svh"

module resultPath (
	input  logic                 clk,
	input  logic                 reset,
	input  logic [`ARM_XLEN-1:0] readData,
	input  logic [`ARM_XLEN-1:0] aluResult,
	input  logic                 pcWrite,
	input  logic                 adrSrc,
	input  ctrlPkg::resultSel_t  resultSel,
	output logic [`ARM_XLEN-1:0] result,
	output logic [`ARM_XLEN-1:0] pcValue,
	output logic [`ARM_XLEN-1:0] adr
);
	import ctrlPkg::*;

	logic [`ARM_XLEN-1:0] aluOut, loadData;

	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			pcValue <= '0;
		else if (pcWrite)
			pcValue <= result;
	end

	// One-cycle holding registers between states
	always_ff @(posedge clk) begin
		aluOut   <= aluResult;
		loadData <= readData;
	end

	always_comb begin
		case (resultSel)
			RES_DATA: result = loadData;
			RES_ALU:  result = aluResult;
			default:  result = aluOut;
		endcase
	end

	// Instruction fetch from PC, data access from the computed address
	assign adr = adrSrc ? result : pcValue;

endmodule

`default_nettype wire

// ==== design/operandPath.sv ====
// Instruction register, register addressing, operand registers, immediate extend, ALU sources
`default_nettype none
`include "armCore_cfg.svh"

module operandPath (
	input  logic                 clk,
	input  logic                 reset,
	input  logic [`ARM_XLEN-1:0] readData,
	input  logic [`ARM_XLEN-1:0] result,
	input  logic                 irWrite,
	input  logic                 regWrite,
	input  logic                 ra1Pc,
	input  logic                 ra2Rd,
	input  logic                 mulRegs,
	input  ctrlPkg::immSel_t     immSel,
	input  logic                 srcASel,
	input  ctrlPkg::srcBSel_t    srcBSel,
	input  logic [`ARM_XLEN-1:0] pcValue,
	output logic [`ARM_XLEN-1:0] instr,
	output logic [`ARM_XLEN-1:0] srcA,
	output logic [`ARM_XLEN-1:0] srcB,
	output logic [`ARM_XLEN-1:0] writeData
);
	import ctrlPkg::*;

	logic [`ARM_REG_ADDR_W-1:0] ra1, ra2, wa;
	logic [`ARM_XLEN-1:0]       rd1, rd2, opA, opB, extImm;

	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			instr <= '0;
		else if (irWrite)
			instr <= readData;
	end

	// MUL reads Rm and Rs and writes the field at 19:16
	assign ra1 = ra1Pc ? `ARM_REG_ADDR_W'(`ARM_PC_REG) : (mulRegs ? instr[3:0] : instr[19:16]);
	assign ra2 = ra2Rd ? instr[15:12] : (mulRegs ? instr[11:8] : instr[3:0]);
	assign wa  = mulRegs ? instr[19:16] : instr[15:12];

	registerFile regs (
		.clk       (clk),
		.writeEn   (regWrite),
		.readAddr1 (ra1),
		.readAddr2 (ra2),
		.writeAddr (wa),
		.writeData (result),
		.pcValue   (result),
		.readData1 (rd1),
		.readData2 (rd2)
	);

	// Operands captured one cycle after they are read
	always_ff @(posedge clk) begin
		opA <= rd1;
		opB <= rd2;
	end

	always_comb begin
		case (immSel)
			IMM_8:      extImm = {{(`ARM_XLEN - 8){1'b0}}, instr[7:0]};
			IMM_12:     extImm = {{(`ARM_XLEN - 12){1'b0}}, instr[11:0]};
			IMM_BRANCH: extImm = {{(`ARM_XLEN - 26){instr[23]}}, instr[23:0], 2'b00};
			default:    extImm = '0;
		endcase
	end

	assign srcA = srcASel ? pcValue : opA;

	always_comb begin
		case (srcBSel)
			SRCB_IMM:  srcB = extImm;
			SRCB_STEP: srcB = `ARM_XLEN'(`ARM_PC_STEP);
			default:   srcB = opB;
		endcase
	end

	// Store data is the second operand, Rd for STR
	assign writeData = opB;

endmodule

`default_nettype wire

// ==== design/aluUnit.sv ====
// ALU with add/subtract, logic ops and low-word multiply, plus NZCV flags
`default_nettype none
`include "armCore_cfg.svh"

module aluUnit (
	input  logic [`ARM_XLEN-1:0] srcA,
	input  logic [`ARM_XLEN-1:0] srcB,
	input  isaPkg::aluOp_t       aluOp,
	output logic [`ARM_XLEN-1:0] aluResult,
	output isaPkg::aluFlags_t    aluFlags
);
	import isaPkg::*;

	logic                 subtract, arith;
	logic [`ARM_XLEN-1:0] bInv;
	logic [`ARM_XLEN:0]   sum;

	assign subtract = (aluOp == ALU_SUB);
	assign arith    = (aluOp == ALU_ADD) || subtract;

	// Subtract as A + ~B + 1
	assign bInv = subtract ? ~srcB : srcB;
	assign sum  = {1'b0, srcA} + {1'b0, bInv} + {{`ARM_XLEN{1'b0}}, subtract};

	always_comb begin
		case (aluOp)
			ALU_AND: aluResult = srcA & srcB;
			ALU_ORR: aluResult = srcA | srcB;
			ALU_EOR: aluResult = srcA ^ srcB;
			ALU_MUL: aluResult = srcA * srcB;  // low word only
			default: aluResult = sum[`ARM_XLEN-1:0];
		endcase
	end

	assign aluFlags.n = aluResult[`ARM_XLEN-1];
	assign aluFlags.z = (aluResult == '0);
	assign aluFlags.c = arith && sum[`ARM_XLEN];
	// Overflow when operands agree in sign and the sum does not
	assign aluFlags.v = arith && !(srcA[`ARM_XLEN-1] ^ srcB[`ARM_XLEN-1] ^ subtract)
		&& (srcA[`ARM_XLEN-1] ^ sum[`ARM_XLEN-1]);

endmodule

`default_nettype wire

// ==== design/registerFile.sv ====
// Register file of fifteen general registers, R15 reads come from the PC path
`default_nettype none
`include "armCore_cfg.svh"

module registerFile (
	input  logic                       clk,
	input  logic                       writeEn,
	input  logic [`ARM_REG_ADDR_W-1:0] readAddr1,
	input  logic [`ARM_REG_ADDR_W-1:0] readAddr2,
	input  logic [`ARM_REG_ADDR_W-1:0] writeAddr,
	input  logic [`ARM_XLEN-1:0]       writeData,
	input  logic [`ARM_XLEN-1:0]       pcValue,
	output logic [`ARM_XLEN-1:0]       readData1,
	output logic [`ARM_XLEN-1:0]       readData2
);
	logic [`ARM_XLEN-1:0] regs [0:`ARM_PC_REG-1];

	always_ff @(posedge clk) begin
		if (writeEn)
			regs[writeAddr] <= writeData;
	end

	// R15 reads see PC+8 from the result bus
	assign readData1 = (readAddr1 == `ARM_REG_ADDR_W'(`ARM_PC_REG)) ? pcValue : regs[readAddr1];
	assign readData2 = (readAddr2 == `ARM_REG_ADDR_W'(`ARM_PC_REG)) ? pcValue : regs[readAddr2];

	noPcWrite: assert property (@(posedge clk)
		writeEn |-> writeAddr != `ARM_REG_ADDR_W'(`ARM_PC_REG));

endmodule

`default_nettype wire

// ==== design/ctrlPkg.sv ====
// Control types: multicycle state encoding and datapath select encodings
`default_nettype none

package ctrlPkg;

	typedef enum logic [3:0] {
		FETCH    = 4'd0,
		DECODE   = 4'd1,
		MEMADR   = 4'd2,
		MEMRD    = 4'd3,
		MEMWB    = 4'd4,
		MEMWR    = 4'd5,
		EXECUTER = 4'd6,
		EXECUTEI = 4'd7,
		ALUWB    = 4'd8,
		BRANCH   = 4'd9
	} cpuState_t;

	// ALU source B
	typedef enum logic [1:0] {
		SRCB_REG  = 2'b00,
		SRCB_IMM  = 2'b01,
		SRCB_STEP = 2'b10
	} srcBSel_t;

	// Value driven onto the result bus
	typedef enum logic [1:0] {
		RES_ALUOUT = 2'b00,
		RES_DATA   = 2'b01,
		RES_ALU    = 2'b10
	} resultSel_t;

	// Immediate extension format
	typedef enum logic [1:0] {
		IMM_8      = 2'b00,
		IMM_12     = 2'b01,
		IMM_BRANCH = 2'b10
	} immSel_t;

endpackage

`default_nettype wire

// ==== design/isaPkg.sv ====
// Instruction-encoding types: condition codes, opcode classes, function codes, ALU ops, flags
`default_nettype none

package isaPkg;

	// Condition field, bits 31:28
	typedef enum logic [3:0] {
		COND_EQ = 4'b0000,
		COND_NE = 4'b0001,
		COND_CS = 4'b0010,
		COND_CC = 4'b0011,
		COND_MI = 4'b0100,
		COND_PL = 4'b0101,
		COND_VS = 4'b0110,
		COND_VC = 4'b0111,
		COND_HI = 4'b1000,
		COND_LS = 4'b1001,
		COND_GE = 4'b1010,
		COND_LT = 4'b1011,
		COND_GT = 4'b1100,
		COND_LE = 4'b1101,
		COND_AL = 4'b1110
	} condCode_t;

	// Op field, bits 27:26
	typedef enum logic [1:0] {
		OP_DP     = 2'b00,
		OP_MEM    = 2'b01,
		OP_BRANCH = 2'b10
	} opClass_t;

	// Data-processing cmd field, bits 24:21
	typedef enum logic [3:0] {
		FN_AND = 4'b0000,
		FN_EOR = 4'b0001,
		FN_SUB = 4'b0010,
		FN_ADD = 4'b0100,
		FN_ORR = 4'b1100
	} dpFunct_t;

	typedef enum logic [2:0] {
		ALU_ADD = 3'b000,
		ALU_SUB = 3'b001,
		ALU_AND = 3'b010,
		ALU_ORR = 3'b011,
		ALU_EOR = 3'b100,
		ALU_MUL = 3'b101
	} aluOp_t;

	typedef struct packed {
		logic n;
		logic z;
		logic c;
		logic v;
	} aluFlags_t;

endpackage

`default_nettype wire

// ==== design/armCore_cfg.svh ====
// Core width macros: word width, register-address width, PC register index and PC step
`ifndef ARM_CORE_CFG_SVH
`define ARM_CORE_CFG_SVH

// Data and address width
`define ARM_XLEN 32

// Register number width, sixteen architectural registers
`define ARM_REG_ADDR_W 4

// R15 is the program counter
`define ARM_PC_REG 15

// Byte step between instruction words
`define ARM_PC_STEP 4

`endif
